// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cacheline_adaptor
RTL_TOP   ?= cacheline_adaptor
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
mem_pkg.sv
line_arbiter.sv
burst_writer.sv
burst_reader.sv
cacheline_adaptor.sv
tb_bmem_model.sv
tb_cacheline_adaptor.sv

// File: burst_reader.sv
`timescale 1ns/1ns

module burst_reader
    import mem_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_rst_n,
    // Granted read from the arbiter
    input  logic                 i_rd_start,
    input  logic [ADDR_BITS-1:0] i_sel_addr,
    // Memory bus command side
    input  logic                 i_bmem_ready,
    output logic [ADDR_BITS-1:0] o_bmem_addr,
    output logic                 o_bmem_read,
    // Memory bus return side
    input  logic [ADDR_BITS-1:0] i_bmem_raddr,
    input  logic [BEAT_BITS-1:0] i_bmem_rdata,
    input  logic                 i_bmem_rvalid,
    // Assembled line and its done pulse
    output logic [LINE_BITS-1:0] o_rd_line,
    output logic                 o_rd_done
);

    logic [LINE_BITS-1:0]     line_q;
    logic [ADDR_BITS-1:0]     addr_q;
    logic [BEAT_IDX_BITS-1:0] beat_cnt;
    // Command waiting for ready
    logic                     cmd_q;
    // Command taken, beats still due
    logic                     wait_q;
    logic                     raddr_match;
    logic                     beat_hit;
    logic                     last_beat;

    // Beats for another line are dropped
    assign raddr_match = (i_bmem_raddr == addr_q);
    assign beat_hit    = wait_q & i_bmem_rvalid & raddr_match;
    assign last_beat   = (beat_cnt == BEAT_IDX_BITS'(BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            cmd_q     <= 1'b0;
            wait_q    <= 1'b0;
            beat_cnt  <= '0;
            o_rd_done <= 1'b0;
        end else begin
            o_rd_done <= 1'b0;
            if (i_rd_start) begin
                cmd_q    <= 1'b1;
                beat_cnt <= '0;
            end else if (cmd_q && i_bmem_ready) begin
                // Accepted, now only beats matter
                cmd_q  <= 1'b0;
                wait_q <= 1'b1;
            end else if (beat_hit) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) begin
                    wait_q    <= 1'b0;
                    o_rd_done <= 1'b1;
                end
            end
        end
    end

    // Address latch and beat slots
    always_ff @(posedge clk) begin
        if (i_rd_start) begin
            addr_q <= i_sel_addr;
        end
        if (beat_hit) begin
            line_q[beat_cnt*BEAT_BITS +: BEAT_BITS] <= i_bmem_rdata;
        end
    end

    // Command held stable until ready
    assign o_bmem_read = cmd_q;
    assign o_bmem_addr = addr_q;
    assign o_rd_line   = line_q;

    // Memory returns our line only after the command is taken
    a_beat_window: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_bmem_rvalid && raddr_match) |-> wait_q);

endmodule

// File: burst_writer.sv
`timescale 1ns/1ns

module burst_writer
    import mem_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_rst_n,
    // Granted write from the arbiter
    input  logic                 i_wr_start,
    input  logic [ADDR_BITS-1:0] i_sel_addr,
    input  logic [LINE_BITS-1:0] i_sel_wdata,
    // Memory bus
    input  logic                 i_bmem_ready,
    output logic [ADDR_BITS-1:0] o_bmem_addr,
    output logic                 o_bmem_write,
    output logic [BEAT_BITS-1:0] o_bmem_wdata,
    // Pulse after the last accepted beat
    output logic                 o_wr_done
);

    logic [LINE_BITS-1:0]     line_q;
    logic [ADDR_BITS-1:0]     addr_q;
    logic [BEAT_IDX_BITS-1:0] beat_cnt;
    logic                     active;
    logic                     beat_acc;
    logic                     last_beat;

    // Beat leaves when write and ready meet
    assign beat_acc  = active & i_bmem_ready;
    assign last_beat = (beat_cnt == BEAT_IDX_BITS'(BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            active    <= 1'b0;
            beat_cnt  <= '0;
            o_wr_done <= 1'b0;
        end else begin
            o_wr_done <= 1'b0;
            if (i_wr_start) begin
                // Beat zero goes out next cycle
                active   <= 1'b1;
                beat_cnt <= '0;
            end else if (beat_acc) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) begin
                    active    <= 1'b0;
                    o_wr_done <= 1'b1;
                end
            end
        end
    end

    // Line and address held for the whole burst
    always_ff @(posedge clk) begin
        if (i_wr_start) begin
            line_q <= i_sel_wdata;
            addr_q <= i_sel_addr;
        end
    end

    // Same line address on every beat
    assign o_bmem_write = active;
    assign o_bmem_addr  = addr_q;
    // Lowest beat first
    assign o_bmem_wdata = line_q[beat_cnt*BEAT_BITS +: BEAT_BITS];

    // Stalled beat keeps its data and address
    a_beat_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_bmem_write && !i_bmem_ready) |=>
            (o_bmem_write && $stable(o_bmem_wdata) && $stable(o_bmem_addr)));

endmodule

// File: cacheline_adaptor.sv
`timescale 1ns/1ns

module cacheline_adaptor
    import mem_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_rst_n,
    // Instruction side line port
    input  logic [ADDR_BITS-1:0] i_ifp_addr,
    input  logic                 i_ifp_read,
    output logic [LINE_BITS-1:0] o_ifp_rdata,
    output logic                 o_ifp_resp,
    // Data side line port
    input  logic [ADDR_BITS-1:0] i_dfp_addr,
    input  logic                 i_dfp_read,
    input  logic                 i_dfp_write,
    input  logic [LINE_BITS-1:0] i_dfp_wdata,
    output logic [LINE_BITS-1:0] o_dfp_rdata,
    output logic                 o_dfp_resp,
    // Burst memory bus
    output logic [ADDR_BITS-1:0] o_bmem_addr,
    output logic                 o_bmem_read,
    output logic                 o_bmem_write,
    output logic [BEAT_BITS-1:0] o_bmem_wdata,
    input  logic                 i_bmem_ready,
    input  logic [ADDR_BITS-1:0] i_bmem_raddr,
    input  logic [BEAT_BITS-1:0] i_bmem_rdata,
    input  logic                 i_bmem_rvalid
);

    // Arbiter to engines
    logic                 wr_start;
    logic                 rd_start;
    logic [ADDR_BITS-1:0] sel_addr;
    logic [LINE_BITS-1:0] sel_wdata;
    logic                 wr_done;
    logic                 rd_done;
    logic [LINE_BITS-1:0] rd_line;

    // Engine bus outputs before merging
    logic [ADDR_BITS-1:0] wr_addr;
    logic                 wr_write;
    logic [ADDR_BITS-1:0] rd_addr;
    logic                 rd_read;

    line_arbiter arbiter_i (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_ifp_addr(i_ifp_addr),
        .i_ifp_read(i_ifp_read),
        .i_dfp_addr(i_dfp_addr),
        .i_dfp_read(i_dfp_read),
        .i_dfp_write(i_dfp_write),
        .i_dfp_wdata(i_dfp_wdata),
        .i_wr_done(wr_done),
        .i_rd_done(rd_done),
        .i_rd_line(rd_line),
        .o_wr_start(wr_start),
        .o_rd_start(rd_start),
        .o_sel_addr(sel_addr),
        .o_sel_wdata(sel_wdata),
        .o_ifp_rdata(o_ifp_rdata),
        .o_ifp_resp(o_ifp_resp),
        .o_dfp_rdata(o_dfp_rdata),
        .o_dfp_resp(o_dfp_resp)
    );

    burst_writer writer_i (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_wr_start(wr_start),
        .i_sel_addr(sel_addr),
        .i_sel_wdata(sel_wdata),
        .i_bmem_ready(i_bmem_ready),
        .o_bmem_addr(wr_addr),
        .o_bmem_write(wr_write),
        .o_bmem_wdata(o_bmem_wdata),
        .o_wr_done(wr_done)
    );

    burst_reader reader_i (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_rd_start(rd_start),
        .i_sel_addr(sel_addr),
        .i_bmem_ready(i_bmem_ready),
        .o_bmem_addr(rd_addr),
        .o_bmem_read(rd_read),
        .i_bmem_raddr(i_bmem_raddr),
        .i_bmem_rdata(i_bmem_rdata),
        .i_bmem_rvalid(i_bmem_rvalid),
        .o_rd_line(rd_line),
        .o_rd_done(rd_done)
    );

    // Address follows whichever engine drives a command
    assign o_bmem_addr  = wr_write ? wr_addr : rd_addr;
    assign o_bmem_read  = rd_read;
    assign o_bmem_write = wr_write;

    // Single open transaction keeps the engines apart on the bus
    a_bus_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(o_bmem_read && o_bmem_write));

endmodule

// File: cacheline_testdata.txt
# kind side op addr line  (kind 0 preload, 1 request, 2 issued with next record)
# side 0 instruction 1 data, op 0 read 1 write, line is write data or expected read
0 0 0 00001000 00000000000000a300000000000000a200000000000000a100000000000000a0
0 0 0 00001020 00000000000000b300000000000000b200000000000000b100000000000000b0
0 0 0 00002000 00000000000000c300000000000000c200000000000000c100000000000000c0
# both sides together right after reset
2 1 0 00001000 00000000000000a300000000000000a200000000000000a100000000000000a0
1 0 0 00002000 00000000000000c300000000000000c200000000000000c100000000000000c0
# instruction read of a preloaded line
1 0 0 00001020 00000000000000b300000000000000b200000000000000b100000000000000b0
# data write then read back
1 1 1 00003000 00000000000000d300000000000000d200000000000000d100000000000000d0
1 1 0 00003000 00000000000000d300000000000000d200000000000000d100000000000000d0
# instruction read of a written line
1 0 0 00003000 00000000000000d300000000000000d200000000000000d100000000000000d0
# more writes under back-pressure
1 1 1 00001020 00000000000000e300000000000000e200000000000000e100000000000000e0
1 1 1 00004040 00000000000000f300000000000000f200000000000000f100000000000000f0
1 0 0 00001020 00000000000000e300000000000000e200000000000000e100000000000000e0
1 1 0 00004040 00000000000000f300000000000000f200000000000000f100000000000000f0
1 1 0 00002000 00000000000000c300000000000000c200000000000000c100000000000000c0

// File: line_arbiter.sv
`timescale 1ns/1ns

module line_arbiter
    import mem_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_rst_n,
    // Instruction side, read only
    input  logic [ADDR_BITS-1:0] i_ifp_addr,
    input  logic                 i_ifp_read,
    // Data side
    input  logic [ADDR_BITS-1:0] i_dfp_addr,
    input  logic                 i_dfp_read,
    input  logic                 i_dfp_write,
    input  logic [LINE_BITS-1:0] i_dfp_wdata,
    // Completion from the engines
    input  logic                 i_wr_done,
    input  logic                 i_rd_done,
    input  logic [LINE_BITS-1:0] i_rd_line,
    // Start towards the engines
    output logic                 o_wr_start,
    output logic                 o_rd_start,
    output logic [ADDR_BITS-1:0] o_sel_addr,
    output logic [LINE_BITS-1:0] o_sel_wdata,
    // Responses back to the requesters
    output logic [LINE_BITS-1:0] o_ifp_rdata,
    output logic                 o_ifp_resp,
    output logic [LINE_BITS-1:0] o_dfp_rdata,
    output logic                 o_dfp_resp
);

    logic                 busy;
    // Owner of the open transaction, also the last-granted pointer
    logic                 owner_dfp;
    logic                 ifp_pend;
    logic                 dfp_pend;
    logic                 pick_dfp;
    logic                 any_done;
    logic [ADDR_BITS-1:0] pick_addr;

    assign ifp_pend = i_ifp_read;
    assign dfp_pend = i_dfp_read | i_dfp_write;

    // Data wins unless it won last time and the instruction side waits
    assign pick_dfp  = dfp_pend & (~ifp_pend | ~owner_dfp);
    assign pick_addr = pick_dfp ? i_dfp_addr : i_ifp_addr;
    assign any_done  = i_wr_done | i_rd_done;

    // Grant FSM, one transaction open at a time
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            busy       <= 1'b0;
            // Cleared pointer means instruction side was last, so data goes first
            owner_dfp  <= 1'b0;
            o_wr_start <= 1'b0;
            o_rd_start <= 1'b0;
        end else begin
            o_wr_start <= 1'b0;
            o_rd_start <= 1'b0;
            if (busy) begin
                if (any_done) begin
                    busy <= 1'b0;
                end
            end else if (ifp_pend | dfp_pend) begin
                busy      <= 1'b1;
                owner_dfp <= pick_dfp;
                // Only data writes use the writer
                o_wr_start <= pick_dfp & i_dfp_write;
                o_rd_start <= ~(pick_dfp & i_dfp_write);
            end
        end
    end

    // Selected request, captured with the start pulse
    always_ff @(posedge clk) begin
        if (!busy && (ifp_pend || dfp_pend)) begin
            o_sel_addr  <= {pick_addr[ADDR_BITS-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
            o_sel_wdata <= i_dfp_wdata;
        end
    end

    // Response lands in the done cycle
    assign o_ifp_resp  = any_done & ~owner_dfp;
    assign o_dfp_resp  = any_done & owner_dfp;
    // Line valid only with the response
    assign o_ifp_rdata = i_rd_line;
    assign o_dfp_rdata = i_rd_line;

    // Engines finish only an open transaction, and never both at once
    a_done_open: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_wr_done || i_rd_done) |-> (busy && !(i_wr_done && i_rd_done)));

endmodule

// File: mem_pkg.sv
package mem_pkg;

    // Byte address on the memory bus and on both requester ports
    localparam int ADDR_BITS = 32;

    // One cacheline as the requesters see it
    localparam int LINE_BITS = 256;

    // One beat on the burst memory bus
    localparam int BEAT_BITS = 64;

    // Beats needed to move a whole line
    localparam int BEATS_PER_LINE = LINE_BITS / BEAT_BITS;

    // Width of a beat counter
    localparam int BEAT_IDX_BITS = $clog2(BEATS_PER_LINE);

    // Bytes in a line
    localparam int LINE_BYTES = LINE_BITS / 8;

    // Low address bits that are zero for a line-aligned address
    localparam int LINE_OFFSET_BITS = $clog2(LINE_BYTES);

    // Memory model and testbench rely on these sizes
    // 4 beats of 64 bits, 32-byte lines
    // Counter of 2 bits covers beats 0 to 3

    // Bus beat must be a whole number of bytes
    localparam int BEAT_BYTES = BEAT_BITS / 8;

    // Beat order on the bus is lowest beat first
    // Beat k of a line lives in line bits [k*64 +: 64]

    // Address is passed to the bus already line-aligned
    // Offset bits are cleared by the arbiter

endpackage

// File: tb_bmem_model.sv
`timescale 1ns/1ns

module tb_bmem_model
    import mem_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic [ADDR_BITS-1:0] i_bmem_addr,
    input  logic                 i_bmem_read,
    input  logic                 i_bmem_write,
    input  logic [BEAT_BITS-1:0] i_bmem_wdata,
    output logic                 o_bmem_ready,
    output logic [ADDR_BITS-1:0] o_bmem_raddr,
    output logic [BEAT_BITS-1:0] o_bmem_rdata,
    output logic                 o_bmem_rvalid
);

    // Whole lines keyed by line address
    logic [LINE_BITS-1:0] mem [logic [ADDR_BITS-1:0]];
    int                   wr_beats = 0;
    logic                 rd_pend = 1'b0;
    logic [ADDR_BITS-1:0] rd_addr = '0;
    int                   rd_wait = 0;
    int                   rd_idx = 0;

    initial begin
        o_bmem_ready  = 1'b0;
        o_bmem_raddr  = '0;
        o_bmem_rdata  = '0;
        o_bmem_rvalid = 1'b0;
    end

    task automatic preload(input logic [ADDR_BITS-1:0] addr, input logic [LINE_BITS-1:0] line);
        mem[addr] = line;
    endtask

    function automatic logic [LINE_BITS-1:0] line_at(input logic [ADDR_BITS-1:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return '0;
    endfunction

    // Accept on the rising edge, drive on the falling edge
    always begin
        logic [LINE_BITS-1:0] cur;
        @(posedge clk);
        if (!i_rst_n) begin
            wr_beats = 0;
            rd_pend  = 1'b0;
        end else begin
            if (i_bmem_write && o_bmem_ready) begin
                cur = line_at(i_bmem_addr);
                cur[wr_beats*BEAT_BITS +: BEAT_BITS] = i_bmem_wdata;
                mem[i_bmem_addr] = cur;
                wr_beats = (wr_beats + 1) % BEATS_PER_LINE;
            end
            if (i_bmem_read && o_bmem_ready) begin
                rd_pend = 1'b1;
                rd_addr = i_bmem_addr;
                // Latency of 1 to 8 cycles
                rd_wait = 1 + int'($urandom % 8);
                rd_idx  = 0;
            end
        end
        @(negedge clk);
        o_bmem_ready  = i_rst_n && ($urandom % 4 != 0);
        o_bmem_rvalid = 1'b0;
        if (rd_pend) begin
            if (rd_wait > 0) begin
                rd_wait = rd_wait - 1;
            end else if ($urandom % 3 != 0) begin
                // Beats may come with gaps
                cur = line_at(rd_addr);
                o_bmem_rvalid = 1'b1;
                o_bmem_raddr  = rd_addr;
                o_bmem_rdata  = cur[rd_idx*BEAT_BITS +: BEAT_BITS];
                rd_idx = rd_idx + 1;
                if (rd_idx == BEATS_PER_LINE) begin
                    rd_pend = 1'b0;
                end
            end
        end
    end

endmodule

// File: tb_cacheline_adaptor.sv
`timescale 1ns/1ns

module tb_cacheline_adaptor;
    import mem_pkg::*;

    logic                 clk;
    logic                 rst_n;
    logic [ADDR_BITS-1:0] ifp_addr;
    logic                 ifp_read;
    logic [LINE_BITS-1:0] ifp_rdata;
    logic                 ifp_resp;
    logic [ADDR_BITS-1:0] dfp_addr;
    logic                 dfp_read;
    logic                 dfp_write;
    logic [LINE_BITS-1:0] dfp_wdata;
    logic [LINE_BITS-1:0] dfp_rdata;
    logic                 dfp_resp;
    logic [ADDR_BITS-1:0] bmem_addr;
    logic                 bmem_read;
    logic                 bmem_write;
    logic [BEAT_BITS-1:0] bmem_wdata;
    logic                 bmem_ready;
    logic [ADDR_BITS-1:0] bmem_raddr;
    logic [BEAT_BITS-1:0] bmem_rdata;
    logic                 bmem_rvalid;

    // Records from the data file
    int                   q_kind[$];
    int                   q_side[$];
    int                   q_op[$];
    logic [ADDR_BITS-1:0] q_addr[$];
    logic [LINE_BITS-1:0] q_line[$];
    // Expected memory contents
    logic [LINE_BITS-1:0] image [logic [ADDR_BITS-1:0]];

    int errors = 0;
    int passed = 0;
    int failed = 0;
    int cycles = 0;
    int limit = 1000000;

    cacheline_adaptor dut (
        .clk(clk), .i_rst_n(rst_n),
        .i_ifp_addr(ifp_addr), .i_ifp_read(ifp_read),
        .o_ifp_rdata(ifp_rdata), .o_ifp_resp(ifp_resp),
        .i_dfp_addr(dfp_addr), .i_dfp_read(dfp_read), .i_dfp_write(dfp_write),
        .i_dfp_wdata(dfp_wdata), .o_dfp_rdata(dfp_rdata), .o_dfp_resp(dfp_resp),
        .o_bmem_addr(bmem_addr), .o_bmem_read(bmem_read), .o_bmem_write(bmem_write),
        .o_bmem_wdata(bmem_wdata), .i_bmem_ready(bmem_ready), .i_bmem_raddr(bmem_raddr),
        .i_bmem_rdata(bmem_rdata), .i_bmem_rvalid(bmem_rvalid)
    );

    tb_bmem_model mem (
        .clk(clk), .i_rst_n(rst_n),
        .i_bmem_addr(bmem_addr), .i_bmem_read(bmem_read), .i_bmem_write(bmem_write),
        .i_bmem_wdata(bmem_wdata), .o_bmem_ready(bmem_ready), .o_bmem_raddr(bmem_raddr),
        .o_bmem_rdata(bmem_rdata), .o_bmem_rvalid(bmem_rvalid)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    // Run limit from the request count
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: a response did not arrive within %0d cycles", limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic compare_line(input string name, input logic [LINE_BITS-1:0] exp,
                                input logic [LINE_BITS-1:0] act);
        if (act !== exp) begin
            $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors = errors + 1;
        end
    endtask

    function automatic logic [ADDR_BITS-1:0] line_addr(input logic [ADDR_BITS-1:0] a);
        return {a[ADDR_BITS-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
    endfunction

    function automatic logic [LINE_BITS-1:0] image_line(input logic [ADDR_BITS-1:0] a);
        if (image.exists(line_addr(a))) begin
            return image[line_addr(a)];
        end
        return '0;
    endfunction

    task automatic read_testdata();
        int                   fd;
        int                   n;
        int                   kind;
        int                   side;
        int                   op;
        logic [ADDR_BITS-1:0] addr;
        logic [LINE_BITS-1:0] line;
        string                text;
        fd = $fopen("cacheline_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            errors = errors + 1;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(text, fd);
                // Skip comments and short lines
                if (n > 8 && text.substr(0, 0) != "#") begin
                    n = $sscanf(text, "%d %d %d %h %h", kind, side, op, addr, line);
                    if (n == 5 && kind == 0) begin
                        mem.preload(line_addr(addr), line);
                        image[line_addr(addr)] = line;
                    end else if (n == 5) begin
                        q_kind.push_back(kind);
                        q_side.push_back(side);
                        q_op.push_back(op);
                        q_addr.push_back(addr);
                        q_line.push_back(line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_request(input int i);
        if (q_side[i] == 1) begin
            dfp_addr  = q_addr[i];
            dfp_read  = (q_op[i] == 0);
            dfp_write = (q_op[i] == 1);
            dfp_wdata = q_line[i];
        end else begin
            ifp_addr = q_addr[i];
            ifp_read = 1'b1;
        end
    endtask

    // Write updates the image, read is checked against it
    task automatic settle_request(input int i, input logic [LINE_BITS-1:0] act);
        if (q_op[i] == 1) begin
            image[line_addr(q_addr[i])] = q_line[i];
        end else begin
            compare_line("testdata line", image_line(q_addr[i]), q_line[i]);
            compare_line(q_side[i] == 1 ? "o_dfp_rdata" : "o_ifp_rdata",
                         image_line(q_addr[i]), act);
        end
    endtask

    task automatic report_test(input int id, input int start_errors);
        if (errors == start_errors) begin
            passed = passed + 1;
            $display("test %0d: pass", id);
        end else begin
            failed = failed + 1;
            $display("test %0d: fail", id);
        end
    endtask

    task automatic run_single(input int i);
        int                   start_errors;
        logic                 got;
        logic [LINE_BITS-1:0] act;
        start_errors = errors;
        got = 1'b0;
        act = '0;
        drive_request(i);
        while (!got) begin
            @(negedge clk);
            if (q_side[i] == 1 ? ifp_resp : dfp_resp) begin
                $display("Response arrived on the side that made no request (test %0d)", i);
                errors = errors + 1;
            end
            if (q_side[i] == 1 ? dfp_resp : ifp_resp) begin
                got = 1'b1;
                act = q_side[i] == 1 ? dfp_rdata : ifp_rdata;
            end
        end
        ifp_read  = 1'b0;
        dfp_read  = 1'b0;
        dfp_write = 1'b0;
        settle_request(i, act);
        @(negedge clk);
        if (ifp_resp || dfp_resp) begin
            $display("Extra response pulse after test %0d", i);
            errors = errors + 1;
        end
        report_test(i, start_errors);
    endtask

    // Data record i and instruction record i+1 issued together
    task automatic run_pair(input int i);
        int                   start_errors;
        logic                 d_got;
        logic                 f_got;
        logic [LINE_BITS-1:0] d_act;
        logic [LINE_BITS-1:0] f_act;
        start_errors = errors;
        d_got = 1'b0;
        f_got = 1'b0;
        d_act = '0;
        f_act = '0;
        drive_request(i);
        drive_request(i + 1);
        while (!(d_got && f_got)) begin
            @(negedge clk);
            if (ifp_resp && !d_got) begin
                $display("Instruction side was served before the data side (test %0d)", i);
                errors = errors + 1;
            end
            if (dfp_resp) begin
                d_got = 1'b1;
                d_act = dfp_rdata;
                dfp_read  = 1'b0;
                dfp_write = 1'b0;
            end
            if (ifp_resp) begin
                f_got = 1'b1;
                f_act = ifp_rdata;
                ifp_read = 1'b0;
            end
        end
        settle_request(i, d_act);
        settle_request(i + 1, f_act);
        report_test(i, start_errors);
    endtask

    initial begin
        int i;
        void'($urandom(10));
        rst_n     = 1'b0;
        ifp_addr  = '0;
        ifp_read  = 1'b0;
        dfp_addr  = '0;
        dfp_read  = 1'b0;
        dfp_write = 1'b0;
        dfp_wdata = '0;
        read_testdata();
        limit = q_kind.size() * 60 + 100;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        i = 0;
        while (i < q_kind.size()) begin
            @(negedge clk);
            if (q_kind[i] == 2 && i + 1 < q_kind.size()) begin
                run_pair(i);
                i = i + 2;
            end else begin
                run_single(i);
                i = i + 1;
            end
        end
        $display("passed %0d failed %0d errors %0d", passed, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
